//--- src/core_pkg.sv
// rv64 base encodings only; no compressed forms, no loads/stores, counters are read-only
package core_pkg;

	// ******************************
	// architecture constants
	// ******************************
	localparam int XLEN = 64;

	// major opcodes
	localparam logic [6:0] OP_IMM    = 7'b0010011;
	localparam logic [6:0] OP_REG    = 7'b0110011;
	localparam logic [6:0] OP_LUI    = 7'b0110111;
	localparam logic [6:0] OP_JAL    = 7'b1101111;
	localparam logic [6:0] OP_BRANCH = 7'b1100011;
	localparam logic [6:0] OP_SYSTEM = 7'b1110011;

	// funct3 values of the supported subset
	localparam logic [2:0] F3_ADD   = 3'b000;
	localparam logic [2:0] F3_SLT   = 3'b010;
	localparam logic [2:0] F3_XOR   = 3'b100;
	localparam logic [2:0] F3_OR    = 3'b110;
	localparam logic [2:0] F3_AND   = 3'b111;
	localparam logic [2:0] F3_BEQ   = 3'b000;
	localparam logic [2:0] F3_BNE   = 3'b001;
	localparam logic [2:0] F3_CSRRS = 3'b010;

	// funct7 for add vs sub
	localparam logic [6:0] F7_BASE = 7'b0000000;
	localparam logic [6:0] F7_SUB  = 7'b0100000;

	// full ebreak word, matched exactly
	localparam logic [31:0] EBREAK_INST = 32'h0010_0073;

	// machine counters
	localparam logic [11:0] CSR_MCYCLE   = 12'hB00;
	localparam logic [11:0] CSR_MINSTRET = 12'hB02;

	// ******************************
	// instruction formats
	// ******************************
	typedef struct packed {
		logic [6:0] funct7;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] rd;
		logic [6:0] opcode;
	} r_fmt_t;

	typedef struct packed {
		logic [11:0] imm;
		logic [4:0]  rs1;
		logic [2:0]  funct3;
		logic [4:0]  rd;
		logic [6:0]  opcode;
	} i_fmt_t;

	typedef struct packed {
		logic [19:0] imm;
		logic [4:0]  rd;
		logic [6:0]  opcode;
	} u_fmt_t;

	// branch offset bits are scattered, bit 0 implied zero
	typedef struct packed {
		logic       imm12;
		logic [5:0] imm10_5;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [3:0] imm4_1;
		logic       imm11;
		logic [6:0] opcode;
	} b_fmt_t;

	typedef struct packed {
		logic       imm20;
		logic [9:0] imm10_1;
		logic       imm11;
		logic [7:0] imm19_12;
		logic [4:0] rd;
		logic [6:0] opcode;
	} j_fmt_t;

	// one word, five views
	typedef union packed {
		r_fmt_t r_fmt;
		i_fmt_t i_fmt;
		u_fmt_t u_fmt;
		b_fmt_t b_fmt;
		j_fmt_t j_fmt;
	} inst_u;

	// ******************************
	// execute and retire records
	// ******************************
	typedef struct packed {
		logic            rd_wen;
		logic [4:0]      rd;
		logic [XLEN-1:0] rd_data;
		logic [XLEN-1:0] next_pc;
		logic            halt;
		logic            illegal;
	} exec_result_t;

	typedef struct packed {
		logic            valid;
		logic [XLEN-1:0] pc;
		logic [4:0]      rd;
		logic            rd_wen;
		logic [XLEN-1:0] rd_data;
	} retire_t;

endpackage

//--- src/core_control.sv
// one instruction in flight, two cycles each; inst must be stable at the edge ending FETCH
`timescale 1ns/1ps

module core_control #(
	parameter logic [core_pkg::XLEN-1:0] RESET_PC = '0
) (
	input  logic                      clk,
	input  logic                      rst,
	input  logic [31:0]               inst,
	input  core_pkg::exec_result_t    result,
	output logic [core_pkg::XLEN-1:0] cur_pc,
	output core_pkg::inst_u           cur_inst,
	output logic                      reg_we,
	output logic                      instret_inc,
	output core_pkg::retire_t         retire,
	output logic                      halted,
	output logic                      illegal
);

	import core_pkg::*;

	typedef enum logic [1:0] {
		FETCH,
		EXEC,
		HALT
	} state_t;

	state_t state;
	logic   illegal_q;

	// ******************************
	// state machine and pc
	// ******************************
	always_ff @(posedge clk) begin
		if (rst) begin
			state     <= FETCH;
			cur_pc    <= RESET_PC;
			illegal_q <= 1'b0;
		end else begin
			case (state)
				FETCH: state <= EXEC;
				EXEC: begin
					// pc moves on even for the halting instruction
					cur_pc <= result.next_pc;
					if (result.halt) begin
						state     <= HALT;
						illegal_q <= result.illegal;
					end else begin
						state <= FETCH;
					end
				end
				// sticky until reset
				default: state <= HALT;
			endcase
		end
	end

	// instruction latch loads only in fetch
	always_ff @(posedge clk) begin
		if (state == FETCH) begin
			cur_inst <= inst;
		end
	end

	// strobes only during execute
	assign reg_we      = (state == EXEC) && result.rd_wen;
	assign instret_inc = (state == EXEC);

	// retire record mirrors the execute cycle
	always_comb begin
		retire.valid   = (state == EXEC);
		retire.pc      = cur_pc;
		retire.rd      = result.rd;
		retire.rd_wen  = result.rd_wen;
		retire.rd_data = result.rd_data;
	end

	assign halted  = (state == HALT);
	assign illegal = illegal_q;

	// ******************************
	// checks
	// ******************************
	// next_pc from the execute unit never breaks word alignment
	a_pc_aligned: assert property (@(posedge clk) disable iff (rst)
		cur_pc[1:0] == 2'b00);

	// a stopping instruction retires with no register write
	a_halt_no_write: assert property (@(posedge clk) disable iff (rst)
		retire.valid && result.halt |-> !reg_we);

endmodule

//--- src/cycle_counter.sv
// CNT_W of 32 or 64; counters wrap silently and read back zero-extended to XLEN
`timescale 1ns/1ps

module cycle_counter #(
	parameter int CNT_W = 64
) (
	input  logic                      clk,
	input  logic                      rst,
	input  logic                      instret_inc,
	input  logic [11:0]               csr_addr,
	output logic [core_pkg::XLEN-1:0] csr_rdata
);

	import core_pkg::*;

	logic [CNT_W-1:0] mcycle;
	logic [CNT_W-1:0] minstret;

	// ******************************
	// counters
	// ******************************
	always_ff @(posedge clk) begin
		if (rst) begin
			mcycle   <= '0;
			minstret <= '0;
		end else begin
			// free running, reads 0 in the first fetch
			mcycle <= mcycle + 1'b1;
			if (instret_inc) begin
				minstret <= minstret + 1'b1;
			end
		end
	end

	// read mux, unknown address gives zero
	always_comb begin
		case (csr_addr)
			CSR_MCYCLE:   csr_rdata = XLEN'(mcycle);
			CSR_MINSTRET: csr_rdata = XLEN'(minstret);
			default:      csr_rdata = '0;
		endcase
	end

	// at most one retire per cycle, so retired count trails cycles
	a_instret_le_cycle: assert property (@(posedge clk) disable iff (rst)
		minstret <= mcycle);

endmodule

//--- src/reg_file.sv
// contents come up undefined; x0 is never stored and always reads zero
`timescale 1ns/1ps

module reg_file (
	input  logic                      clk,
	input  logic [4:0]                rs1_addr,
	input  logic [4:0]                rs2_addr,
	output logic [core_pkg::XLEN-1:0] rs1_data,
	output logic [core_pkg::XLEN-1:0] rs2_data,
	input  logic                      we,
	input  logic [4:0]                rd_addr,
	input  logic [core_pkg::XLEN-1:0] rd_data
);

	import core_pkg::*;

	logic [XLEN-1:0] regs [32];

	// ******************************
	// write port
	// ******************************
	always_ff @(posedge clk) begin
		// x0 writes dropped here
		if (we && (rd_addr != 5'd0)) begin
			regs[rd_addr] <= rd_data;
		end
	end

	// ******************************
	// read ports, asynchronous
	// ******************************
	// entry 0 never written, so force zero on read
	assign rs1_data = (rs1_addr == 5'd0) ? '0 : regs[rs1_addr];
	assign rs2_data = (rs2_addr == 5'd0) ? '0 : regs[rs2_addr];

endmodule

//--- src/exec_unit.sv
// purely combinational; branch/jal targets are not checked for alignment
`timescale 1ns/1ps

module exec_unit (
	input  logic [core_pkg::XLEN-1:0] pc,
	input  core_pkg::inst_u           inst,
	output logic [4:0]                rs1_addr,
	output logic [4:0]                rs2_addr,
	input  logic [core_pkg::XLEN-1:0] rs1_data,
	input  logic [core_pkg::XLEN-1:0] rs2_data,
	output logic [11:0]               csr_addr,
	input  logic [core_pkg::XLEN-1:0] csr_rdata,
	output core_pkg::exec_result_t    result
);

	import core_pkg::*;

	logic [XLEN-1:0] imm_i;
	logic [XLEN-1:0] imm_u;
	logic [XLEN-1:0] imm_b;
	logic [XLEN-1:0] imm_j;
	logic [XLEN-1:0] pc_plus4;
	logic            slt;

	// register and csr fields sit at the same bits in every format
	assign rs1_addr = inst.r_fmt.rs1;
	assign rs2_addr = inst.r_fmt.rs2;
	assign csr_addr = inst.i_fmt.imm;

	// ******************************
	// immediates, sign extended
	// ******************************
	assign imm_i = {{52{inst.i_fmt.imm[11]}}, inst.i_fmt.imm};
	// lui result sign extends on rv64
	assign imm_u = {{32{inst.u_fmt.imm[19]}}, inst.u_fmt.imm, 12'b0};
	assign imm_b = {{51{inst.b_fmt.imm12}}, inst.b_fmt.imm12, inst.b_fmt.imm11,
		inst.b_fmt.imm10_5, inst.b_fmt.imm4_1, 1'b0};
	assign imm_j = {{43{inst.j_fmt.imm20}}, inst.j_fmt.imm20, inst.j_fmt.imm19_12,
		inst.j_fmt.imm11, inst.j_fmt.imm10_1, 1'b0};

	assign pc_plus4 = pc + XLEN'(4);
	assign slt      = $signed(rs1_data) < $signed(rs2_data);

	// ******************************
	// decode and execute
	// ******************************
	always_comb begin
		// defaults: fall through, no write
		result.rd_wen  = 1'b0;
		result.rd      = inst.r_fmt.rd;
		result.rd_data = '0;
		result.next_pc = pc_plus4;
		result.halt    = 1'b0;
		result.illegal = 1'b0;

		case (inst.r_fmt.opcode)
			OP_IMM: begin
				result.rd_wen = 1'b1;
				case (inst.i_fmt.funct3)
					F3_ADD:  result.rd_data = rs1_data + imm_i;
					F3_XOR:  result.rd_data = rs1_data ^ imm_i;
					default: result.illegal = 1'b1;
				endcase
			end
			OP_REG: begin
				result.rd_wen = 1'b1;
				case ({inst.r_fmt.funct7, inst.r_fmt.funct3})
					{F7_BASE, F3_ADD}: result.rd_data = rs1_data + rs2_data;
					{F7_SUB, F3_ADD}:  result.rd_data = rs1_data - rs2_data;
					{F7_BASE, F3_AND}: result.rd_data = rs1_data & rs2_data;
					{F7_BASE, F3_OR}:  result.rd_data = rs1_data | rs2_data;
					{F7_BASE, F3_XOR}: result.rd_data = rs1_data ^ rs2_data;
					{F7_BASE, F3_SLT}: result.rd_data = {{(XLEN-1){1'b0}}, slt};
					default:           result.illegal = 1'b1;
				endcase
			end
			OP_LUI: begin
				result.rd_wen  = 1'b1;
				result.rd_data = imm_u;
			end
			OP_JAL: begin
				// link is the fall-through address
				result.rd_wen  = 1'b1;
				result.rd_data = pc_plus4;
				result.next_pc = pc + imm_j;
			end
			OP_BRANCH: begin
				case (inst.b_fmt.funct3)
					F3_BEQ: begin
						if (rs1_data == rs2_data) result.next_pc = pc + imm_b;
					end
					F3_BNE: begin
						if (rs1_data != rs2_data) result.next_pc = pc + imm_b;
					end
					default: result.illegal = 1'b1;
				endcase
			end
			OP_SYSTEM: begin
				if (inst == EBREAK_INST) begin
					result.halt = 1'b1;
				end else if (inst.i_fmt.funct3 == F3_CSRRS && inst.i_fmt.rs1 == 5'd0 &&
					(csr_addr == CSR_MCYCLE || csr_addr == CSR_MINSTRET)) begin
					// read-only use, rs1 = x0 means no set bits
					result.rd_wen  = 1'b1;
					result.rd_data = csr_rdata;
				end else begin
					result.illegal = 1'b1;
				end
			end
			default: result.illegal = 1'b1;
		endcase

		// illegal stops the core too; a halting instruction never writes
		if (result.illegal) begin
			result.halt = 1'b1;
		end
		if (result.halt) begin
			result.rd_wen = 1'b0;
		end
	end

endmodule

//--- src/core_top.sv
// instruction port only, no data memory; inst must follow fetch_pc before each rising edge
`timescale 1ns/1ps

module core_top #(
	parameter logic [core_pkg::XLEN-1:0] RESET_PC = '0,
	parameter int                        CNT_W    = 64
) (
	input  logic                      clk,
	input  logic                      rst,
	output logic [core_pkg::XLEN-1:0] fetch_pc,
	input  logic [31:0]               inst,
	output core_pkg::retire_t         retire,
	output logic                      halted,
	output logic                      illegal
);

	import core_pkg::*;

	// ******************************
	// internal wiring
	// ******************************
	inst_u           cur_inst;
	exec_result_t    result;
	logic            reg_we;
	logic            instret_inc;
	logic [4:0]      rs1_addr;
	logic [4:0]      rs2_addr;
	logic [XLEN-1:0] rs1_data;
	logic [XLEN-1:0] rs2_data;
	logic [11:0]     csr_addr;
	logic [XLEN-1:0] csr_rdata;

	// fetch/execute sequencing, pc doubles as fetch address
	core_control #(
		.RESET_PC (RESET_PC)
	) u_control (
		.clk         (clk),
		.rst         (rst),
		.inst        (inst),
		.result      (result),
		.cur_pc      (fetch_pc),
		.cur_inst    (cur_inst),
		.reg_we      (reg_we),
		.instret_inc (instret_inc),
		.retire      (retire),
		.halted      (halted),
		.illegal     (illegal)
	);

	// mcycle / minstret
	cycle_counter #(
		.CNT_W (CNT_W)
	) u_counter (
		.clk         (clk),
		.rst         (rst),
		.instret_inc (instret_inc),
		.csr_addr    (csr_addr),
		.csr_rdata   (csr_rdata)
	);

	// write data comes straight from the execute result
	reg_file u_regs (
		.clk      (clk),
		.rs1_addr (rs1_addr),
		.rs2_addr (rs2_addr),
		.rs1_data (rs1_data),
		.rs2_data (rs2_data),
		.we       (reg_we),
		.rd_addr  (result.rd),
		.rd_data  (result.rd_data)
	);

	exec_unit u_exec (
		.pc        (fetch_pc),
		.inst      (cur_inst),
		.rs1_addr  (rs1_addr),
		.rs2_addr  (rs2_addr),
		.rs1_data  (rs1_data),
		.rs2_data  (rs2_data),
		.csr_addr  (csr_addr),
		.csr_rdata (csr_rdata),
		.result    (result)
	);

endmodule

//--- verif/tb_ref_model.svh
// included inside a module that imports core_pkg; counters are modeled by the 2k+1 / k rule
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

// ******************************
// architectural state
// ******************************
logic [XLEN-1:0] ref_pc;
logic [XLEN-1:0] ref_regs [32];
int              ref_idx;
logic            ref_halt;
logic            ref_illegal;

// back to the reset view, x0 included
task automatic ref_reset(input logic [XLEN-1:0] pc);
	ref_pc      = pc;
	ref_idx     = 0;
	ref_halt    = 1'b0;
	ref_illegal = 1'b0;
	for (int i = 0; i < 32; i++) begin
		ref_regs[i] = '0;
	end
endtask

// one instruction from its raw bits, returns the expected retire record
function automatic retire_t ref_step(input logic [31:0] w);
	retire_t         r;
	logic [6:0]      op;
	logic [2:0]      f3;
	logic [6:0]      f7;
	logic [XLEN-1:0] a;
	logic [XLEN-1:0] b;
	logic [XLEN-1:0] imm_i;
	logic [XLEN-1:0] imm_u;
	logic [XLEN-1:0] imm_b;
	logic [XLEN-1:0] imm_j;
	logic [XLEN-1:0] npc;
	logic            ok;
	logic            stop;

	op = w[6:0];
	f3 = w[14:12];
	f7 = w[31:25];
	a  = ref_regs[w[19:15]];
	b  = ref_regs[w[24:20]];
	// immediates straight from the spec bit positions
	imm_i = {{52{w[31]}}, w[31:20]};
	imm_u = {{32{w[31]}}, w[31:12], 12'b0};
	imm_b = {{51{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
	imm_j = {{43{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};

	r.valid   = 1'b1;
	r.pc      = ref_pc;
	r.rd      = w[11:7];
	r.rd_wen  = 1'b1;
	r.rd_data = '0;
	npc       = ref_pc + 64'd4;
	ok        = 1'b1;
	stop      = 1'b0;

	case (op)
		OP_IMM: begin
			if (f3 == F3_ADD) r.rd_data = a + imm_i;
			else if (f3 == F3_XOR) r.rd_data = a ^ imm_i;
			else ok = 1'b0;
		end
		OP_REG: begin
			if (f7 == F7_SUB && f3 == F3_ADD) r.rd_data = a - b;
			else if (f7 != F7_BASE) ok = 1'b0;
			else if (f3 == F3_ADD) r.rd_data = a + b;
			else if (f3 == F3_AND) r.rd_data = a & b;
			else if (f3 == F3_OR) r.rd_data = a | b;
			else if (f3 == F3_XOR) r.rd_data = a ^ b;
			else if (f3 == F3_SLT) r.rd_data = ($signed(a) < $signed(b)) ? 64'd1 : 64'd0;
			else ok = 1'b0;
		end
		OP_LUI: r.rd_data = imm_u;
		OP_JAL: begin
			r.rd_data = ref_pc + 64'd4;
			npc       = ref_pc + imm_j;
		end
		OP_BRANCH: begin
			r.rd_wen = 1'b0;
			if (f3 == F3_BEQ) begin
				if (a == b) npc = ref_pc + imm_b;
			end else if (f3 == F3_BNE) begin
				if (a != b) npc = ref_pc + imm_b;
			end else begin
				ok = 1'b0;
			end
		end
		OP_SYSTEM: begin
			if (w == 32'h0010_0073) stop = 1'b1;
			else if (f3 != F3_CSRRS || w[19:15] != 5'd0) ok = 1'b0;
			// k-th instruction executes in cycle 2k+1
			else if (w[31:20] == CSR_MCYCLE) r.rd_data = XLEN'(2 * ref_idx + 1);
			else if (w[31:20] == CSR_MINSTRET) r.rd_data = XLEN'(ref_idx);
			else ok = 1'b0;
		end
		default: ok = 1'b0;
	endcase

	if (!ok) begin
		stop        = 1'b1;
		ref_illegal = 1'b1;
	end
	// stopping instruction retires without a write
	if (stop) begin
		r.rd_wen  = 1'b0;
		r.rd_data = '0;
		ref_halt  = 1'b1;
	end
	if (r.rd_wen && r.rd != 5'd0) begin
		ref_regs[r.rd] = r.rd_data;
	end
	ref_pc  = npc;
	ref_idx = ref_idx + 1;
	return r;
endfunction

`endif

//--- verif/tb_core.sv
// two runs from reset; random programs read only registers that are surely written before
`timescale 1ns/1ps

module tb_core;

	import core_pkg::*;

	localparam int              CLK_PERIOD = 20;
	localparam int              PROG_LEN   = 48;
	localparam int              PROG_WORDS = 64;
	localparam int              ILL_IDX    = 20;
	localparam int              NUM_RUNS   = 2;
	localparam logic [XLEN-1:0] RESET_PC   = '0;
	// a load opcode lies outside the supported set
	localparam logic [31:0]     ILL_WORD   = 32'h0000_3083;

	logic            clk;
	logic            rst;
	logic [31:0]     inst;
	logic [XLEN-1:0] fetch_pc;
	retire_t         retire;
	logic            halted;
	logic            illegal;

	logic [31:0]     prog [PROG_WORDS];
	integer          seed = 32'hb6fd4734;
	int              retired;
	logic [XLEN-1:0] last_pc;

	`include "tb_ref_model.svh"

	core_top #(
		.RESET_PC (RESET_PC),
		.CNT_W    (64)
	) UUT (
		.clk      (clk),
		.rst      (rst),
		.fetch_pc (fetch_pc),
		.inst     (inst),
		.retire   (retire),
		.halted   (halted),
		.illegal  (illegal)
	);

	// ******************************
	// helpers
	// ******************************
	task automatic check_val(input string name, input logic [XLEN-1:0] exp,
		input logic [XLEN-1:0] act);
		if (act !== exp) begin
			$display("** Error at %0d ns: %s expected %h got %h", $time, name, exp, act);
			$display("Simulation FAILED");
			$fatal(1, "mismatch on %s", name);
		end
	endtask

	function automatic int pick(input int n);
		return $unsigned($random(seed)) % n;
	endfunction

	// word at a byte address with ebreak past the end or while pc is unknown
	function automatic logic [31:0] fetch_word(input logic [XLEN-1:0] pc);
		logic [XLEN-1:0] idx;
		idx = (pc - RESET_PC) >> 2;
		if ($isunknown(pc) || idx >= PROG_WORDS) return EBREAK_INST;
		return prog[idx];
	endfunction

	// encoders through the union views
	function automatic logic [31:0] enc_r(input logic [6:0] f7, input int rs2, input int rs1,
		input logic [2:0] f3, input int rd);
		inst_u w;
		w.r_fmt = '{f7, rs2[4:0], rs1[4:0], f3, rd[4:0], OP_REG};
		return w;
	endfunction

	function automatic logic [31:0] enc_i(input logic [11:0] imm, input int rs1,
		input logic [2:0] f3, input int rd, input logic [6:0] op);
		inst_u w;
		w.i_fmt = '{imm, rs1[4:0], f3, rd[4:0], op};
		return w;
	endfunction

	function automatic logic [31:0] enc_u(input logic [19:0] imm, input int rd);
		inst_u w;
		w.u_fmt = '{imm, rd[4:0], OP_LUI};
		return w;
	endfunction

	function automatic logic [31:0] enc_b(input int off, input int rs2, input int rs1,
		input logic [2:0] f3);
		inst_u       w;
		logic [12:0] o;
		o = off[12:0];
		w.b_fmt = '{o[12], o[10:5], rs2[4:0], rs1[4:0], f3, o[4:1], o[11], OP_BRANCH};
		return w;
	endfunction

	function automatic logic [31:0] enc_j(input int off, input int rd);
		inst_u       w;
		logic [20:0] o;
		o = off[20:0];
		w.j_fmt = '{o[20], o[10:1], o[11], o[19:12], rd[4:0], OP_JAL};
		return w;
	endfunction

	// ******************************
	// program generation
	// ******************************
	// only x0..x7 so writes get reused; jumps go 1..4 words forward
	task automatic gen_program(input int ill_idx);
		logic [7:0]  written;
		logic [31:0] r;
		int          reach;
		int          lim;
		int          off;
		int          rd;
		int          rs1;
		int          rs2;
		logic        sure;
		begin
			written = 8'h01;
			reach   = 0;
			for (int i = 0; i < PROG_WORDS; i++) begin
				prog[i] = EBREAK_INST;
			end
			for (int i = 0; i < PROG_LEN; i++) begin
				r   = $random(seed);
				rd  = pick(8);
				rs1 = written[r[2:0]] ? int'(r[2:0]) : 0;
				rs2 = written[r[5:3]] ? int'(r[5:3]) : 0;
				// no jump may pass the illegal slot
				lim = (ill_idx >= 0 && i < ill_idx) ? ill_idx : PROG_LEN;
				off = 1 + pick(4);
				if (i + off > lim) off = lim - i;
				// executed for sure once no earlier jump lands beyond it
				sure = (i >= reach);
				case (pick(12))
					0: prog[i] = enc_i(r[31:20], rs1, F3_ADD, rd, OP_IMM);
					1: prog[i] = enc_i(r[31:20], rs1, F3_XOR, rd, OP_IMM);
					2: prog[i] = enc_r(F7_BASE, rs2, rs1, F3_ADD, rd);
					3: prog[i] = enc_r(F7_SUB, rs2, rs1, F3_ADD, rd);
					4: prog[i] = enc_r(F7_BASE, rs2, rs1, F3_AND, rd);
					5: prog[i] = enc_r(F7_BASE, rs2, rs1, F3_OR, rd);
					6: prog[i] = enc_r(F7_BASE, rs2, rs1, F3_XOR, rd);
					7: prog[i] = enc_r(F7_BASE, rs2, rs1, F3_SLT, rd);
					8: prog[i] = enc_u(r[31:12], rd);
					9: begin
						prog[i] = enc_j(4 * off, rd);
						if (i + off > reach) reach = i + off;
					end
					10: begin
						// equal operands now and then so beq is taken
						if (r[6]) rs2 = rs1;
						prog[i] = enc_b(4 * off, rs2, rs1, r[7] ? F3_BNE : F3_BEQ);
						if (i + off > reach) reach = i + off;
						rd = 0;
					end
					default: prog[i] = enc_i(r[8] ? CSR_MINSTRET : CSR_MCYCLE, 0, F3_CSRRS,
						rd, OP_SYSTEM);
				endcase
				if (sure) written[rd] = 1'b1;
			end
			if (ill_idx >= 0) prog[ill_idx] = ILL_WORD;
		end
	endtask

	// expected run length from a dry pass of the model over the program
	task automatic count_steps(output int n);
		n = 0;
		ref_reset(RESET_PC);
		while (!ref_halt) begin
			void'(ref_step(fetch_word(ref_pc)));
			n = n + 1;
		end
		ref_reset(RESET_PC);
	endtask

	// ******************************
	// clock, feed, compare
	// ******************************
	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	// word for the current pc goes out on the falling edge
	always @(negedge clk) begin
		inst <= fetch_word(fetch_pc);
	end

	always @(posedge clk) begin
		retire_t exp;
		if (rst === 1'b0 && retire.valid === 1'b1) begin
			if (ref_halt) begin
				// nothing may retire after the stop
				check_val("retire.valid", '0, XLEN'(retire.valid));
			end else begin
				exp = ref_step(fetch_word(ref_pc));
				check_val("retire.pc", exp.pc, retire.pc);
				check_val("retire.rd", XLEN'(exp.rd), XLEN'(retire.rd));
				check_val("retire.rd_wen", XLEN'(exp.rd_wen), XLEN'(retire.rd_wen));
				if (exp.rd_wen) check_val("retire.rd_data", exp.rd_data, retire.rd_data);
				retired = retired + 1;
				last_pc = retire.pc;
			end
		end
	end

	// ******************************
	// runs
	// ******************************
	task automatic run_program(input int ill_idx);
		int exp_count;
		rst = 1'b1;
		gen_program(ill_idx);
		count_steps(exp_count);
		retired = 0;
		last_pc = '0;
		repeat (2) @(posedge clk);
		@(negedge clk);
		// reset state before release
		check_val("retire.valid", '0, XLEN'(retire.valid));
		check_val("halted", '0, XLEN'(halted));
		check_val("illegal", '0, XLEN'(illegal));
		check_val("fetch_pc", RESET_PC, fetch_pc);
		rst = 1'b0;
		while (halted !== 1'b1) @(negedge clk);
		repeat (3) @(negedge clk);
		check_val("halted", XLEN'(1), XLEN'(halted));
		check_val("illegal", XLEN'(ref_illegal), XLEN'(illegal));
		check_val("retired count", XLEN'(exp_count), XLEN'(retired));
		// stop comes from the illegal slot or the closing ebreak
		if (ill_idx >= 0) check_val("last retire.pc", RESET_PC + 4 * ill_idx, last_pc);
		else check_val("last retire.pc", RESET_PC + 4 * PROG_LEN, last_pc);
	endtask

	initial begin
		rst     = 1'b1;
		inst    = EBREAK_INST;
		retired = 0;
		run_program(-1);
		run_program(ILL_IDX);
		$display("Simulation PASSED");
		$finish;
	end

	// longest legal run plus reset and drain margin for each run
	initial begin
		#(NUM_RUNS * (PROG_LEN + 8) * 2 * CLK_PERIOD);
		$display("timeout: the core never halted");
		$display("Simulation FAILED");
		$fatal(1, "watchdog expired");
	end

endmodule

//--- files.f
+incdir+verif
src/core_pkg.sv
src/core_control.sv
src/cycle_counter.sv
src/reg_file.sv
src/exec_unit.sv
src/core_top.sv
verif/tb_core.sv

//--- Bender.yml
package:
  name: rv64_core

sources:
  - src/core_pkg.sv
  - src/core_control.sv
  - src/cycle_counter.sv
  - src/reg_file.sv
  - src/exec_unit.sv
  - src/core_top.sv
  - target: test
    include_dirs:
      - verif
    files:
      - verif/tb_core.sv
